//--- src/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

   // port widths
   localparam int W_DATA_W = 32;
   localparam int R_DATA_W = 8;

   // bytes per word, also the number of memory banks
   localparam int N_BANKS = W_DATA_W / R_DATA_W;

   // address widths in bytes, words and bank rows
   localparam int ADDR_W      = 6;
   localparam int W_ADDR_W    = 4;
   localparam int BANK_ADDR_W = 4;

   localparam int FIFO_BYTES = 64;

   // saturating event counters
   localparam int CNT_W = 16;

   typedef logic [W_DATA_W-1:0] word_t;
   typedef logic [R_DATA_W-1:0] byte_t;
   typedef logic [ADDR_W-1:0]   byte_addr_t;
   typedef logic [W_ADDR_W-1:0] word_addr_t;
   typedef logic [N_BANKS-1:0]  bank_en_t;
   typedef logic [ADDR_W:0]     level_t;
   typedef logic [CNT_W-1:0]    cnt_t;

endpackage

`default_nettype wire

//--- src/ext_mem_if.sv
`timescale 1ns/1ns
`default_nettype none

interface ext_mem_if import fifo_pkg::*; ();

   // write port, one enable per byte lane
   bank_en_t   w_en;
   word_t      w_data;
   word_addr_t w_addr;

   // read port, data returns one cycle after r_en
   logic       r_en;
   word_addr_t r_addr;
   word_t      r_data;

   modport ram (
      output w_en,
      output w_data,
      output w_addr,
      output r_en,
      output r_addr,
      input  r_data
   );

   modport mem (
      input  w_en,
      input  w_data,
      input  w_addr,
      input  r_en,
      input  r_addr,
      output r_data
   );

endinterface

`default_nettype wire

//--- src/ram_banked.sv
`timescale 1ns/1ns
`default_nettype none

module ram_banked import fifo_pkg::*; (
   input wire logic clk,
   ext_mem_if.mem   mem
);

   // one array per byte lane
   byte_t bank_mem [N_BANKS][2**BANK_ADDR_W];

   word_t r_word;

   always_ff @(posedge clk) begin
      // each lane writes on its own enable
      for (int b = 0; b < N_BANKS; b++) begin
         if (mem.w_en[b]) begin
            bank_mem[b][mem.w_addr] <= mem.w_data[b*R_DATA_W +: R_DATA_W];
         end
      end

      // full word read, all lanes at the same row
      if (mem.r_en) begin
         for (int b = 0; b < N_BANKS; b++) begin
            r_word[b*R_DATA_W +: R_DATA_W] <= bank_mem[b][mem.r_addr];
         end
      end
   end

   assign mem.r_data = r_word;

endmodule

`default_nettype wire

//--- src/ram_2p_asym.sv
`timescale 1ns/1ns
`default_nettype none

module ram_2p_asym import fifo_pkg::*; (
   input  wire logic       clk,

   // word write side
   input  wire logic       w_en,
   input  wire word_t      w_data,
   input  wire word_addr_t w_addr,

   // byte read side
   input  wire logic       r_en,
   input  wire byte_addr_t r_addr,
   output      byte_t      r_data,

   ext_mem_if.ram          ext_mem
);

   // lane index of the byte in flight
   logic [ADDR_W-W_ADDR_W-1:0] lane_q;

   // a word write fills every lane of one row
   assign ext_mem.w_en   = {N_BANKS{w_en}};
   assign ext_mem.w_data = w_data;
   assign ext_mem.w_addr = w_addr;

   // upper address bits pick the row
   assign ext_mem.r_en   = r_en;
   assign ext_mem.r_addr = r_addr[ADDR_W-1 -: W_ADDR_W];

   // low bits follow the memory latency
   always_ff @(posedge clk) begin
      if (r_en) begin
         lane_q <= r_addr[ADDR_W-W_ADDR_W-1:0];
      end
   end

   // lane 0 holds bits 7:0, so bytes leave little-endian
   always_comb begin
      r_data = ext_mem.r_data[R_DATA_W-1:0];
      for (int b = 1; b < N_BANKS; b++) begin
         if (int'(lane_q) == b) begin
            r_data = ext_mem.r_data[b*R_DATA_W +: R_DATA_W];
         end
      end
   end

endmodule

`default_nettype wire

//--- src/fifo_sync_asym.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_sync_asym import fifo_pkg::*; (
   input  wire logic  clk,
   input  wire logic  rst,

   // write port, one word per strobe
   input  wire logic  w_en,
   input  wire word_t w_data,
   output      logic  w_full,

   // read port, one byte per strobe
   input  wire logic  r_en,
   output      byte_t r_data,
   output      logic  r_empty,

   // occupancy in bytes
   output      level_t level,

   ext_mem_if.ram     ext_mem
);

   word_addr_t w_addr;
   byte_addr_t r_addr;
   level_t     level_nxt;

   // strobes arrive pre-gated, no full or empty check here
   always_comb begin
      case ({w_en, r_en})
         2'b10:   level_nxt = level + level_t'(N_BANKS);
         2'b01:   level_nxt = level - level_t'(1);
         2'b11:   level_nxt = level + level_t'(N_BANKS - 1);
         default: level_nxt = level;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         w_addr  <= '0;
         r_addr  <= '0;
         level   <= '0;
         w_full  <= 1'b0;
         r_empty <= 1'b1;
      end else begin
         if (w_en) begin
            w_addr <= w_addr + word_addr_t'(1);
         end
         if (r_en) begin
            r_addr <= r_addr + byte_addr_t'(1);
         end
         level <= level_nxt;

         // full once another whole word would not fit
         w_full  <= level_nxt > level_t'(FIFO_BYTES - N_BANKS);
         r_empty <= level_nxt == '0;
      end
   end

   // storage
   ram_2p_asym ram_2p_asym0 (
      .clk     (clk),
      .w_en    (w_en),
      .w_data  (w_data),
      .w_addr  (w_addr),
      .r_en    (r_en),
      .r_addr  (r_addr),
      .r_data  (r_data),
      .ext_mem (ext_mem)
   );

endmodule

`default_nettype wire

//--- src/word_ingress.sv
`timescale 1ns/1ns
`default_nettype none

module word_ingress import fifo_pkg::*; (
   input  wire logic  clk,
   input  wire logic  rst,

   // incoming words
   input  wire logic  in_en,
   input  wire word_t in_data,

   // FIFO write side
   input  wire logic  w_full,
   output      logic  w_en,
   output      word_t w_data,

   output      cnt_t  drop_count
);

   logic drop;

   // a full FIFO never sees the strobe
   assign w_en   = in_en & ~w_full;
   assign w_data = in_data;
   assign drop   = in_en & w_full;

   // saturating drop counter
   always_ff @(posedge clk) begin
      if (rst) begin
         drop_count <= '0;
      end else if (drop && drop_count != '1) begin
         drop_count <= drop_count + cnt_t'(1);
      end
   end

endmodule

`default_nettype wire

//--- src/byte_egress.sv
`timescale 1ns/1ns
`default_nettype none

module byte_egress import fifo_pkg::*; (
   input  wire logic  clk,
   input  wire logic  rst,

   // sink request
   input  wire logic  out_en,

   // FIFO read side
   input  wire logic  r_empty,
   output      logic  r_en,
   input  wire byte_t r_data,

   // outgoing bytes
   output      logic  out_valid,
   output      byte_t out_data,

   output      cnt_t  underrun_count
);

   logic underrun;

   // pop only when a byte is there
   assign r_en     = out_en & ~r_empty;
   assign underrun = out_en & r_empty;

   // read data lands one cycle after the pop
   assign out_data = r_data;

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid      <= 1'b0;
         underrun_count <= '0;
      end else begin
         out_valid <= r_en;
         // saturates at all ones
         if (underrun && underrun_count != '1) begin
            underrun_count <= underrun_count + cnt_t'(1);
         end
      end
   end

endmodule

`default_nettype wire

//--- src/width_conv_top.sv
`timescale 1ns/1ns
`default_nettype none

module width_conv_top import fifo_pkg::*; (
   input  wire logic   clk,
   input  wire logic   rst,

   // word input
   input  wire logic   in_en,
   input  wire word_t  in_data,

   // byte output
   input  wire logic   out_en,
   output      logic   out_valid,
   output      byte_t  out_data,

   // status
   output      level_t level,
   output      cnt_t   drop_count,
   output      cnt_t   underrun_count
);

   // producer to FIFO
   logic  w_en;
   word_t w_data;
   logic  w_full;

   // FIFO to consumer
   logic  r_en;
   byte_t r_data;
   logic  r_empty;

   ext_mem_if mem_if ();

   word_ingress word_ingress0 (
      .clk        (clk),
      .rst        (rst),
      .in_en      (in_en),
      .in_data    (in_data),
      .w_full     (w_full),
      .w_en       (w_en),
      .w_data     (w_data),
      .drop_count (drop_count)
   );

   fifo_sync_asym fifo_sync_asym0 (
      .clk     (clk),
      .rst     (rst),
      .w_en    (w_en),
      .w_data  (w_data),
      .w_full  (w_full),
      .r_en    (r_en),
      .r_data  (r_data),
      .r_empty (r_empty),
      .level   (level),
      .ext_mem (mem_if.ram)
   );

   // banked storage behind the FIFO
   ram_banked ram_banked0 (
      .clk (clk),
      .mem (mem_if.mem)
   );

   byte_egress byte_egress0 (
      .clk            (clk),
      .rst            (rst),
      .out_en         (out_en),
      .r_empty        (r_empty),
      .r_en           (r_en),
      .r_data         (r_data),
      .out_valid      (out_valid),
      .out_data       (out_data),
      .underrun_count (underrun_count)
   );

endmodule

`default_nettype wire

//--- verification/tb_util.svh
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// galois lfsr, one step per bit taken
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
logic [31:0] lfsr_state = 32'd1;

// result bookkeeping
int    error_count     = 0;
int    test_count      = 0;
int    failed_tests    = 0;
int    errors_at_start = 0;
string cur_test        = "";

function automatic logic lfsr_bit();
   logic out;
   out = lfsr_state[0];
   lfsr_state = lfsr_state >> 1;
   if (out) begin
      lfsr_state = lfsr_state ^ LFSR_TAPS;
   end
   return out;
endfunction

function automatic logic [31:0] lfsr_bits(int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      v[i] = lfsr_bit();
   end
   return v;
endfunction

task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
   $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
   error_count++;
endtask

task automatic start_test(string name);
   cur_test = name;
   errors_at_start = error_count;
endtask

task automatic finish_test();
   int n;
   n = error_count - errors_at_start;
   test_count++;
   if (n == 0) begin
      $display("test %s: ok", cur_test);
   end else begin
      failed_tests++;
      $display("test %s: failed with %0d errors", cur_test, n);
   end
endtask

task automatic report_summary();
   $display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, error_count);
endtask

`endif

//--- verification/tb_width_conv.sv
`timescale 1ns/1ns
`default_nettype none

module tb_width_conv import fifo_pkg::*;;

   `include "tb_util.svh"

   // rough length of all tests in cycles
   localparam int RUN_CYCLES      = 1300;
   localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES + 400;

   logic   clk;
   logic   rst;
   logic   in_en;
   word_t  in_data;
   logic   out_en;
   logic   out_valid;
   byte_t  out_data;
   level_t level;
   cnt_t   drop_count;
   cnt_t   underrun_count;

   // reference model state
   byte_t model_q [$];
   int    m_level;
   cnt_t  m_drop;
   cnt_t  m_under;
   logic  m_valid;
   byte_t m_byte;
   int    valid_seen;
   int    bytes_in;
   logic  accept;
   logic  pop;

   width_conv_top dut0 (
      .clk            (clk),
      .rst            (rst),
      .in_en          (in_en),
      .in_data        (in_data),
      .out_en         (out_en),
      .out_valid      (out_valid),
      .out_data       (out_data),
      .level          (level),
      .drop_count     (drop_count),
      .underrun_count (underrun_count)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // byte queue model with a little-endian push per accepted word
   always @(posedge clk) begin
      if (rst) begin
         model_q.delete();
         m_level    <= 0;
         m_drop     <= '0;
         m_under    <= '0;
         m_valid    <= 1'b0;
         m_byte     <= '0;
         valid_seen <= 0;
         bytes_in   <= 0;
      end else begin
         accept = in_en && m_level <= FIFO_BYTES - N_BANKS;
         pop    = out_en && m_level != 0;
         if (out_valid) begin
            valid_seen <= valid_seen + 1;
         end
         m_valid <= pop;
         if (pop) begin
            m_byte <= model_q.pop_front();
         end
         if (accept) begin
            for (int b = 0; b < N_BANKS; b++) begin
               model_q.push_back(in_data[b*R_DATA_W +: R_DATA_W]);
            end
            bytes_in <= bytes_in + N_BANKS;
         end
         m_level <= m_level + (accept ? N_BANKS : 0) - (pop ? 1 : 0);
         if (in_en && !accept && m_drop != '1) begin
            m_drop <= m_drop + cnt_t'(1);
         end
         if (out_en && m_level == 0 && m_under != '1) begin
            m_under <= m_under + cnt_t'(1);
         end
      end
   end

   a_level: assert property (@(posedge clk) disable iff (rst) level == level_t'(m_level))
      else report_mismatch("level", 32'($sampled(level)), 32'($sampled(m_level)));
   a_drop: assert property (@(posedge clk) disable iff (rst) drop_count == m_drop)
      else report_mismatch("drop_count", 32'($sampled(drop_count)), 32'($sampled(m_drop)));
   a_under: assert property (@(posedge clk) disable iff (rst) underrun_count == m_under)
      else report_mismatch("underrun_count", 32'($sampled(underrun_count)),
                           32'($sampled(m_under)));
   a_valid: assert property (@(posedge clk) disable iff (rst) out_valid == m_valid)
      else report_mismatch("out_valid", 32'($sampled(out_valid)), 32'($sampled(m_valid)));
   a_data: assert property (@(posedge clk) disable iff (rst) out_valid |-> out_data == m_byte)
      else report_mismatch("out_data", 32'($sampled(out_data)), 32'($sampled(m_byte)));

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic check_equal(string name, logic [31:0] got, logic [31:0] exp);
      assert (got == exp) else report_mismatch(name, got, exp);
   endtask

   // pops until level reads zero so nothing underruns
   task automatic drain_fifo();
      while (level != '0) begin
         out_en = 1'b1;
         step();
      end
      out_en = 1'b0;
      step();
   endtask

   task automatic test_reset_state();
      start_test("reset_state");
      rst = 1'b1;
      repeat (10) step();
      rst = 1'b0;
      check_equal("level", 32'(level), 0);
      check_equal("out_valid", 32'(out_valid), 0);
      check_equal("drop_count", 32'(drop_count), 0);
      check_equal("underrun_count", 32'(underrun_count), 0);
      finish_test();
   endtask

   task automatic test_byte_order();
      int seen0;
      start_test("byte_order");
      seen0 = valid_seen;
      for (int i = 0; i < 3; i++) begin
         in_en   = 1'b1;
         in_data = 32'h0302_0100 + 32'(i) * 32'h0404_0404;
         step();
      end
      in_en  = 1'b0;
      out_en = 1'b1;
      while (level != '0) step();
      // a few cycles on the empty FIFO
      repeat (3) step();
      out_en = 1'b0;
      step();
      check_equal("out_valid count", valid_seen - seen0, 12);
      finish_test();
   endtask

   task automatic test_level_accounting();
      start_test("level_accounting");
      for (int k = 1; k <= 5; k++) begin
         in_en   = 1'b1;
         in_data = lfsr_bits(32);
         step();
         check_equal("level", 32'(level), 4 * k);
      end
      in_en = 1'b0;
      for (int r = 1; r <= 3; r++) begin
         out_en = 1'b1;
         step();
         check_equal("level", 32'(level), 20 - r);
      end
      // write and read together
      in_en   = 1'b1;
      in_data = lfsr_bits(32);
      step();
      check_equal("level", 32'(level), 20);
      in_en  = 1'b0;
      out_en = 1'b0;
      drain_fifo();
      finish_test();
   endtask

   task automatic test_full_drop();
      int   seen0;
      cnt_t drop0;
      start_test("full_drop");
      seen0 = valid_seen;
      drop0 = drop_count;
      in_en = 1'b1;
      repeat (20) begin
         in_data = lfsr_bits(32);
         step();
      end
      in_en = 1'b0;
      check_equal("level", 32'(level), 64);
      check_equal("drop_count delta", 32'(drop_count - drop0), 4);
      drain_fifo();
      check_equal("out_valid count", valid_seen - seen0, 64);
      finish_test();
   endtask

   task automatic test_underrun();
      int   seen0;
      cnt_t under0;
      start_test("underrun");
      seen0  = valid_seen;
      under0 = underrun_count;
      out_en = 1'b1;
      repeat (5) step();
      out_en = 1'b0;
      step();
      check_equal("underrun_count delta", 32'(underrun_count - under0), 5);
      check_equal("out_valid count", valid_seen - seen0, 0);
      finish_test();
   endtask

   task automatic test_random_traffic();
      int seen0;
      int in0;
      start_test("random_traffic");
      seen0 = valid_seen;
      in0   = bytes_in;
      repeat (1000) begin
         in_en   = lfsr_bit();
         in_data = lfsr_bits(32);
         // reads three cycles in four
         out_en  = lfsr_bit() | lfsr_bit();
         step();
      end
      in_en  = 1'b0;
      out_en = 1'b0;
      drain_fifo();
      // every accepted byte leaves exactly once
      check_equal("out_valid count", valid_seen - seen0, bytes_in - in0);
      finish_test();
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      rst     = 1'b1;
      in_en   = 1'b0;
      in_data = '0;
      out_en  = 1'b0;
      test_reset_state();
      test_byte_order();
      test_level_accounting();
      test_full_drop();
      test_underrun();
      test_random_traffic();
      report_summary();
      if (error_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+verification
src/fifo_pkg.sv
src/ext_mem_if.sv
src/ram_banked.sv
src/ram_2p_asym.sv
src/fifo_sync_asym.sv
src/word_ingress.sv
src/byte_egress.sv
src/width_conv_top.sv
verification/tb_width_conv.sv

//--- run_sim.sh
#!/bin/sh
# build and run the width converter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module tb_width_conv -f sources.f
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

out=$(./obj_dir/Vtb_width_conv)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
   exit 0
fi
exit 1
